/* verilog/memPkg.sv */
package memPkg;

    // address space of the shared RAM
    localparam int AddrW    = 12;
    localparam int RamDepth = 4096;

    localparam int ByteW = 8;
    localparam int WordW = 32;

    // byte counter inside the sequencer, counts 0..4
    localparam int CntW = 3;

    typedef logic [AddrW-1:0] addrT;
    typedef logic [ByteW-1:0] byteT;
    typedef logic [WordW-1:0] wordT;
    typedef logic [WordW-1:0] instT;

    // 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        szByte = 2'd0,
        szHalf = 2'd1,
        szWord = 2'd2
    } sizeT;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } opT;

    // current owner of the memory
    typedef enum logic {
        srcFetch = 1'b0,
        srcData  = 1'b1
    } srcT;

endpackage

/* verilog/memReqIf.sv */
`timescale 1ns/1ps

interface memReqIf;

    // job fields, valid only with start
    logic          start;
    memPkg::opT    op;
    memPkg::sizeT  size;
    memPkg::addrT  addr;
    memPkg::wordT  wdata;

    // job status and result
    logic          busy;
    logic          done;
    memPkg::wordT  rdata;

    modport arb (
        output start, op, size, addr, wdata,
        input  busy, done, rdata
    );

    modport seq (
        input  start, op, size, addr, wdata,
        output busy, done, rdata
    );

endinterface

/* verilog/byteRam.sv */
`timescale 1ns/1ps

module byteRam (
    input  logic          clk,
    input  logic          we,
    input  memPkg::addrT  addr,
    input  memPkg::byteT  wdata,
    output memPkg::byteT  rdata
);

    memPkg::byteT mem [memPkg::RamDepth];

    // registered read, old data on a write to the same byte
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* verilog/memCtrl.sv */
`timescale 1ns/1ps

module memCtrl (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,

    memReqIf.seq          req,

    output logic          ramWe,
    output memPkg::addrT  ramAddr,
    output memPkg::byteT  ramWdata,
    input  memPkg::byteT  ramRdata
);

    logic [memPkg::CntW-1:0] cnt;
    logic [memPkg::CntW-1:0] nBytes;
    logic                    busyQ;
    logic                    accept;
    logic                    isLoad;
    logic                    lastCycle;
    logic [1:0]              lastLane;

    memPkg::addrT  base;
    memPkg::sizeT  sizeQ;
    memPkg::opT    opQ;
    memPkg::wordT  storeWord;
    memPkg::wordT  acc;
    memPkg::wordT  assembled;

    function automatic logic [memPkg::CntW-1:0] byteCount(input memPkg::sizeT size);
        logic [memPkg::CntW-1:0] n;
        case (size)
            memPkg::szByte: n = 3'd1;
            memPkg::szHalf: n = 3'd2;
            default:        n = 3'd4;
        endcase
        return n;
    endfunction

    assign accept = req.start && !busyQ;
    assign isLoad = (opQ == memPkg::opLoad);
    assign nBytes = byteCount(sizeQ);

    // loads wait one extra cycle for the last byte
    assign lastCycle = isLoad ? (cnt == nBytes) : (cnt == nBytes - 3'd1);

    // cnt is one ahead of the byte now on ramRdata
    assign lastLane = 2'(cnt - 3'd1);

    always_comb begin
        assembled = acc;
        if (cnt != '0) begin
            assembled[lastLane*8 +: 8] = ramRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busyQ <= 1'b0;
            cnt   <= '0;
        end else if (rdy) begin
            if (accept) begin
                busyQ <= 1'b1;
                cnt   <= '0;
            end else if (busyQ) begin
                if (lastCycle) begin
                    busyQ <= 1'b0;
                    cnt   <= '0;
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (accept) begin
                base      <= req.addr;
                sizeQ     <= req.size;
                opQ       <= req.op;
                storeWord <= req.wdata;
                // upper lanes stay zero for short loads
                acc       <= '0;
            end else if (busyQ && isLoad && cnt != '0) begin
                acc <= assembled;
            end
        end
    end

    // one byte per cycle, little-endian
    // previous address while stalled so ramRdata keeps its byte
    assign ramAddr  = base + memPkg::addrT'(rdy ? cnt : cnt - 3'd1);
    assign ramWdata = storeWord[cnt[1:0]*8 +: 8];
    assign ramWe    = rdy && busyQ && !isLoad;

    assign req.busy  = busyQ;
    assign req.done  = rdy && busyQ && lastCycle;
    assign req.rdata = assembled;

endmodule

/* verilog/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,

    input  logic          fetchEn,
    input  memPkg::addrT  fetchAddr,

    input  logic          dataEn,
    input  memPkg::opT    dataOp,
    input  memPkg::sizeT  dataSize,
    input  memPkg::addrT  dataAddr,
    input  memPkg::wordT  dataWdata,

    output logic          fetchDone,
    output logic          dataDone,
    output memPkg::instT  fetchInst,
    output memPkg::wordT  dataRdata,
    output logic          fetchWait,
    output logic          dataWait,

    memReqIf.arb          req
);

    logic          startQ;
    logic          active;
    memPkg::srcT   owner;
    logic          pick;

    memPkg::opT    jobOp;
    memPkg::sizeT  jobSize;
    memPkg::addrT  jobAddr;
    memPkg::wordT  jobWdata;

    memPkg::instT  instQ;
    memPkg::wordT  dataQ;

    // idle and someone is asking
    assign pick = !active && !req.busy && (dataEn || fetchEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            startQ <= 1'b0;
            active <= 1'b0;
            owner  <= memPkg::srcFetch;
        end else if (rdy) begin
            startQ <= 1'b0;
            if (pick) begin
                startQ <= 1'b1;
                active <= 1'b1;
                // data side has priority
                owner  <= dataEn ? memPkg::srcData : memPkg::srcFetch;
            end else if (active && req.done) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (pick) begin
                if (dataEn) begin
                    jobOp    <= dataOp;
                    jobSize  <= dataSize;
                    jobAddr  <= dataAddr;
                    jobWdata <= dataWdata;
                end else begin
                    // a fetch is a plain word load
                    jobOp    <= memPkg::opLoad;
                    jobSize  <= memPkg::szWord;
                    jobAddr  <= fetchAddr;
                    jobWdata <= '0;
                end
            end
            if (fetchDone) begin
                instQ <= req.rdata;
            end
            if (dataDone) begin
                dataQ <= req.rdata;
            end
        end
    end

    assign req.start = startQ;
    assign req.op    = jobOp;
    assign req.size  = jobSize;
    assign req.addr  = jobAddr;
    assign req.wdata = jobWdata;

    assign fetchDone = active && (owner == memPkg::srcFetch) && req.done;
    assign dataDone  = active && (owner == memPkg::srcData) && req.done;

    // result visible in the done cycle, held afterwards
    assign fetchInst = fetchDone ? req.rdata : instQ;
    assign dataRdata = dataDone ? req.rdata : dataQ;

    assign fetchWait = active && (owner == memPkg::srcFetch);
    assign dataWait  = active && (owner == memPkg::srcData);

endmodule

/* verilog/memSys.sv */
`timescale 1ns/1ps

module memSys (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,

    input  logic          fetchEn,
    input  memPkg::addrT  fetchAddr,
    output logic          fetchDone,
    output memPkg::instT  fetchInst,

    input  logic          dataEn,
    input  memPkg::opT    dataOp,
    input  memPkg::sizeT  dataSize,
    input  memPkg::addrT  dataAddr,
    input  memPkg::wordT  dataWdata,
    output logic          dataDone,
    output memPkg::wordT  dataRdata,

    output logic          fetchWait,
    output logic          dataWait
);

    logic          ramWe;
    memPkg::addrT  ramAddr;
    memPkg::byteT  ramWdata;
    memPkg::byteT  ramRdata;

    memReqIf i_req ();

    memArbiter i_arb (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataOp    (dataOp),
        .dataSize  (dataSize),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .fetchDone (fetchDone),
        .dataDone  (dataDone),
        .fetchInst (fetchInst),
        .dataRdata (dataRdata),
        .fetchWait (fetchWait),
        .dataWait  (dataWait),
        .req       (i_req.arb)
    );

    memCtrl i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .req      (i_req.seq),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam i_ram (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

/* verif/memSys_props.sv */
`timescale 1ns/1ps

module memSysProps (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic done,
    input logic fetchDone,
    input logic dataDone,
    input logic fetchWait,
    input logic dataWait
);

    startIdle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("start raised while the sequencer is busy");

    // every job end reaches exactly one requester
    doneRouted: assert property (@(posedge clk) disable iff (rst)
        done |-> (fetchDone ^ dataDone))
        else $error("sequencer done not routed to exactly one requester");

    fetchPulse: assert property (@(posedge clk) disable iff (rst) fetchDone |=> !fetchDone)
        else $error("fetchDone held longer than one cycle");

    dataPulse: assert property (@(posedge clk) disable iff (rst) dataDone |=> !dataDone)
        else $error("dataDone held longer than one cycle");

    // one owner shown for the whole job
    ownerShown: assert property (@(posedge clk) disable iff (rst)
        busy |-> (fetchWait ^ dataWait))
        else $error("wait flags do not show a single owner while busy");

endmodule

bind memArbiter memSysProps i_props (
    .clk       (clk),
    .rst       (rst),
    .start     (req.start),
    .busy      (req.busy),
    .done      (req.done),
    .fetchDone (fetchDone),
    .dataDone  (dataDone),
    .fetchWait (fetchWait),
    .dataWait  (dataWait)
);

/* verif/tbMemSys.sv */
`timescale 1ns/1ps

module tbMemSys;

    localparam int Timeout = 40;

    typedef enum logic [2:0] {doFetch, doLoad, doStore, doBoth, doStall} kindT;

    typedef struct packed {
        kindT          kind;
        memPkg::sizeT  size;
        memPkg::addrT  addr;
        memPkg::wordT  wdata;
        memPkg::wordT  want;
        // random store value, or expected value taken from refMem
        logic          rnd;
    } rowT;

    logic          clk, rst, rdy;
    logic          fetchEn, fetchDone, fetchWait;
    logic          dataEn, dataDone, dataWait;
    memPkg::addrT  fetchAddr, dataAddr;
    memPkg::instT  fetchInst;
    memPkg::opT    dataOp;
    memPkg::sizeT  dataSize;
    memPkg::wordT  dataWdata, dataRdata;

    memPkg::byteT  refMem [memPkg::RamDepth];
    integer        seed = 32'h6cd3;

    rowT rows [14] = '{
        '{doStore, memPkg::szWord, 12'h100, 32'h1234_5678, 32'h0, 1'b0},
        '{doLoad,  memPkg::szWord, 12'h100, 32'h0, 32'h1234_5678, 1'b0},
        '{doStore, memPkg::szByte, 12'h101, 32'h0000_00ab, 32'h0, 1'b0},
        '{doStore, memPkg::szHalf, 12'h102, 32'h0000_cdef, 32'h0, 1'b0},
        '{doLoad,  memPkg::szWord, 12'h100, 32'h0, 32'h0, 1'b1},
        '{doLoad,  memPkg::szByte, 12'h103, 32'h0, 32'h0000_00cd, 1'b0},
        '{doLoad,  memPkg::szHalf, 12'h101, 32'h0, 32'h0000_efab, 1'b0},
        '{doFetch, memPkg::szWord, 12'h100, 32'h0, 32'hcdef_ab78, 1'b0},
        '{doStore, memPkg::szWord, 12'h200, 32'h0, 32'h0, 1'b1},
        '{doFetch, memPkg::szWord, 12'h200, 32'h0, 32'h0, 1'b1},
        '{doStore, memPkg::szHalf, 12'h203, 32'h0, 32'h0, 1'b1},
        '{doLoad,  memPkg::szWord, 12'h201, 32'h0, 32'h0, 1'b1},
        '{doBoth,  memPkg::szHalf, 12'h100, 32'h0, 32'h0, 1'b1},
        '{doStall, memPkg::szWord, 12'h200, 32'h0, 32'h0, 1'b1}
    };

    memSys i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkData(input string what, input memPkg::wordT want,
                             input memPkg::wordT got);
        if (got !== want) begin
            abortRun($sformatf("mismatch at %0t: %s expected %h got %h",
                               $time, what, want, got));
        end
    endtask

    task automatic checkInst(input string what, input memPkg::instT want,
                             input memPkg::instT got);
        if (got !== want) begin
            abortRun($sformatf("mismatch at %0t: %s expected %h got %h",
                               $time, what, want, got));
        end
    endtask

    function automatic int sizeBytes(input memPkg::sizeT sz);
        return (sz == memPkg::szByte) ? 1 : (sz == memPkg::szHalf) ? 2 : 4;
    endfunction

    // little-endian, upper bytes zero
    function automatic memPkg::wordT refRead(input memPkg::addrT a, input memPkg::sizeT sz);
        memPkg::wordT w;
        w = '0;
        for (int k = 0; k < sizeBytes(sz); k++) begin
            w[k*8 +: 8] = refMem[memPkg::addrT'(a + k)];
        end
        return w;
    endfunction

    task automatic raiseData(input memPkg::opT op, input memPkg::sizeT sz,
                             input memPkg::addrT a, input memPkg::wordT wd);
        @(posedge clk);
        #1;
        dataEn    = 1'b1;
        dataOp    = op;
        dataSize  = sz;
        dataAddr  = a;
        dataWdata = wd;
    endtask

    // wait for one side's done, grab its result, then drop that enable
    task automatic waitDone(input logic fetchSide, output memPkg::wordT got);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            if (!fetchSide && fetchDone === 1'b1) begin
                abortRun("fetch finished ahead of the data access");
            end
            n++;
        end while ((fetchSide ? fetchDone : dataDone) !== 1'b1 && n < Timeout);
        if ((fetchSide ? fetchDone : dataDone) !== 1'b1) begin
            abortRun("done never arrived");
        end
        if ((fetchSide ? fetchWait : dataWait) !== 1'b1) begin
            abortRun("ownership flag low while its access completes");
        end
        got = fetchSide ? fetchInst : dataRdata;
        @(posedge clk);
        #1;
        fetchEn = fetchEn && !fetchSide;
        dataEn  = dataEn && fetchSide;
    endtask

    initial begin
        memPkg::wordT got;
        memPkg::wordT want;
        memPkg::wordT wd;
        int           stall;
        rst       = 1'b1;
        rdy       = 1'b1;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataOp    = memPkg::opLoad;
        dataSize  = memPkg::szByte;
        dataAddr  = '0;
        dataWdata = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (rows[i]) begin
            repeat ($unsigned($random(seed)) % 3) @(posedge clk);
            wd   = rows[i].rnd ? $random(seed) : rows[i].wdata;
            want = rows[i].rnd ? refRead(rows[i].addr, rows[i].size) : rows[i].want;
            if (rows[i].kind == doFetch) begin
                @(posedge clk);
                #1;
                fetchEn   = 1'b1;
                fetchAddr = rows[i].addr;
                waitDone(1'b1, got);
                checkInst("fetch", want, got);
            end else begin
                raiseData(rows[i].kind == doStore ? memPkg::opStore : memPkg::opLoad,
                          rows[i].size, rows[i].addr, wd);
                if (rows[i].kind == doBoth) begin
                    fetchEn   = 1'b1;
                    fetchAddr = rows[i].addr;
                end
                if (rows[i].kind == doStall) begin
                    // freeze halfway through the word
                    repeat (4) @(posedge clk);
                    #1;
                    rdy   = 1'b0;
                    stall = 1 + $unsigned($random(seed)) % 6;
                    repeat (stall) begin
                        @(negedge clk);
                        if (dataDone !== 1'b0) begin
                            abortRun("done pulse while rdy was low");
                        end
                    end
                    @(posedge clk);
                    #1;
                    rdy = 1'b1;
                end
                waitDone(1'b0, got);
                if (rows[i].kind == doStore) begin
                    for (int k = 0; k < sizeBytes(rows[i].size); k++) begin
                        refMem[memPkg::addrT'(rows[i].addr + k)] = wd[k*8 +: 8];
                    end
                end else begin
                    checkData("load", want, got);
                end
                if (rows[i].kind == doBoth) begin
                    waitDone(1'b1, got);
                    checkInst("fetch after data", refRead(rows[i].addr, memPkg::szWord), got);
                end
            end
        end

        @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

/* tb.f */
verilog/memPkg.sv
verilog/memReqIf.sv
verilog/byteRam.sv
verilog/memCtrl.sv
verilog/memArbiter.sv
verilog/memSys.sv
verif/memSys_props.sv
verif/tbMemSys.sv

/* Makefile */
TOP := tbMemSys

sim:
	verilator --binary --assert --top-module $(TOP) -f tb.f -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

.PHONY: sim clean
